//--- hw/brst_pkg.sv
/*
 * Shared definitions for the AXI4 read burst splitter
 * Bus field widths and vector types
 * Burst type encoding and the controller state encodings
 */

`default_nettype none

package brst_pkg;

  // Bus field widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned SIZE_W = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SIZE_W-1:0] size_t;

  // AXI burst type, WRAP is not handled
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1
  } burst_e;

  // AR splitter FSM
  typedef enum logic {AR_IDLE, AR_BUSY} ar_state_e;

  // R channel controller FSM
  typedef enum logic {R_FEED, R_WAIT} r_state_e;

endpackage

`default_nettype wire

//--- hw/ar_splitter.sv
/*
 * AR channel splitter
 * Accepts an upstream read burst, requests a beat counter for it
 * and issues one single-beat read downstream per beat
 */

`default_nettype none

module ar_splitter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              s_ar_valid_i,
  output logic              s_ar_ready_o,
  input  brst_pkg::id_t     s_ar_id_i,
  input  brst_pkg::addr_t   s_ar_addr_i,
  input  brst_pkg::len_t    s_ar_len_i,
  input  brst_pkg::size_t   s_ar_size_i,
  input  brst_pkg::burst_e  s_ar_burst_i,
  output logic              m_ar_valid_o,
  input  logic              m_ar_ready_i,
  output brst_pkg::id_t     m_ar_id_o,
  output brst_pkg::addr_t   m_ar_addr_o,
  output logic              alloc_req_o,
  input  logic              alloc_gnt_i,
  output brst_pkg::id_t     alloc_id_o,
  output brst_pkg::len_t    alloc_len_o
);

  brst_pkg::ar_state_e state_d, state_q;

  // Stored burst, len_q counts the reads left after the current one
  brst_pkg::id_t    id_d, id_q;
  brst_pkg::addr_t  addr_d, addr_q;
  brst_pkg::len_t   len_d, len_q;
  brst_pkg::size_t  size_d, size_q;
  brst_pkg::burst_e burst_d, burst_q;

  // Address of the following beat, FIXED keeps the address
  function automatic brst_pkg::addr_t next_addr(brst_pkg::addr_t addr,
                                                brst_pkg::size_t size,
                                                brst_pkg::burst_e burst);
    brst_pkg::addr_t step;
    step = brst_pkg::addr_t'(1) << size;
    if (burst == brst_pkg::BURST_INCR) begin
      return addr + step;
    end
    return addr;
  endfunction

  // The counter request always describes the burst on the upstream port
  assign alloc_id_o  = s_ar_id_i;
  assign alloc_len_o = s_ar_len_i;

  always_comb begin
    state_d      = state_q;
    id_d         = id_q;
    addr_d       = addr_q;
    len_d        = len_q;
    size_d       = size_q;
    burst_d      = burst_q;
    s_ar_ready_o = 1'b0;
    alloc_req_o  = 1'b0;
    m_ar_valid_o = 1'b0;
    m_ar_id_o    = id_q;
    m_ar_addr_o  = addr_q;

    case (state_q)
      brst_pkg::AR_IDLE: begin
        if (s_ar_valid_i && alloc_gnt_i) begin
          m_ar_valid_o = 1'b1;
          m_ar_id_o    = s_ar_id_i;
          m_ar_addr_o  = s_ar_addr_i;
          if (s_ar_len_i == '0) begin
            // Single beat, pass through once downstream takes it
            if (m_ar_ready_i) begin
              alloc_req_o  = 1'b1;
              s_ar_ready_o = 1'b1;
            end
          end else begin
            alloc_req_o  = 1'b1;
            s_ar_ready_o = 1'b1;
            id_d         = s_ar_id_i;
            size_d       = s_ar_size_i;
            burst_d      = s_ar_burst_i;
            addr_d       = s_ar_addr_i;
            len_d        = s_ar_len_i;
            if (m_ar_ready_i) begin
              addr_d = next_addr(s_ar_addr_i, s_ar_size_i, s_ar_burst_i);
              len_d  = s_ar_len_i - brst_pkg::len_t'(1);
            end
            state_d = brst_pkg::AR_BUSY;
          end
        end
      end
      brst_pkg::AR_BUSY: begin
        m_ar_valid_o = 1'b1;
        if (m_ar_ready_i) begin
          if (len_q == '0) begin
            state_d = brst_pkg::AR_IDLE;
          end else begin
            len_d  = len_q - brst_pkg::len_t'(1);
            addr_d = next_addr(addr_q, size_q, burst_q);
          end
        end
      end
      default: state_d = brst_pkg::AR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= brst_pkg::AR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q    <= id_d;
    addr_q  <= addr_d;
    len_q   <= len_d;
    size_q  <= size_d;
    burst_q <= burst_d;
  end

endmodule

`default_nettype wire

//--- hw/rd_len_counters.sv
/*
 * Pool of read beat counters
 * One slot per outstanding burst, tagged with the burst ID
 * Allocation takes the lowest free slot, lookup matches by ID
 */

`default_nettype none

module rd_len_counters #(
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            alloc_req_i,
  output logic            alloc_gnt_o,
  input  brst_pkg::id_t   alloc_id_i,
  input  brst_pkg::len_t  alloc_len_i,
  input  logic            lk_req_i,
  input  brst_pkg::id_t   lk_id_i,
  output logic            lk_hit_o,
  output brst_pkg::len_t  lk_remain_o,
  input  logic            lk_dec_i
);

  localparam int unsigned IDX_W = (MAX_TXNS > 1) ? $clog2(MAX_TXNS) : 1;

  // One extra bit so that len+1 fits for a 256 beat burst
  localparam logic [brst_pkg::LEN_W:0] CNT_ONE = 1;

  logic                    live_q [MAX_TXNS];
  brst_pkg::id_t           id_q   [MAX_TXNS];
  logic [brst_pkg::LEN_W:0] cnt_q [MAX_TXNS];

  logic                     any_free;
  logic                     id_busy;
  logic [IDX_W-1:0]         free_idx;
  logic                     found;
  logic [IDX_W-1:0]         hit_idx;
  logic [brst_pkg::LEN_W:0] cnt_m1;
  logic                     do_alloc;
  logic                     do_dec;

  // ---------------------------------------------------------------------------
  // Free slot search and ID collision check
  // ---------------------------------------------------------------------------
  always_comb begin
    any_free = 1'b0;
    id_busy  = 1'b0;
    free_idx = '0;
    // Walk downwards so that the lowest free slot is the one kept
    for (int i = MAX_TXNS - 1; i >= 0; i--) begin
      if (!live_q[i]) begin
        any_free = 1'b1;
        free_idx = IDX_W'(i);
      end else if (id_q[i] == alloc_id_i) begin
        id_busy = 1'b1;
      end
    end
  end

  // One burst per ID at a time
  assign alloc_gnt_o = any_free && !id_busy;
  assign do_alloc    = alloc_req_i && alloc_gnt_o;

  // ---------------------------------------------------------------------------
  // Lookup by R ID
  // ---------------------------------------------------------------------------
  always_comb begin
    found   = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      if (live_q[i] && (id_q[i] == lk_id_i)) begin
        found   = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  assign lk_hit_o    = lk_req_i && found;
  assign cnt_m1      = cnt_q[hit_idx] - CNT_ONE;
  assign lk_remain_o = cnt_m1[brst_pkg::LEN_W-1:0];
  assign do_dec      = lk_hit_o && lk_dec_i;

  // ---------------------------------------------------------------------------
  // Slot state
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MAX_TXNS; i++) begin
        live_q[i] <= 1'b0;
      end
    end else begin
      if (do_alloc) begin
        live_q[free_idx] <= 1'b1;
      end
      // Last beat of the burst frees the slot
      if (do_dec && (cnt_m1 == '0)) begin
        live_q[hit_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_alloc) begin
      id_q[free_idx]  <= alloc_id_i;
      cnt_q[free_idx] <= {1'b0, alloc_len_i} + CNT_ONE;
    end
    if (do_dec) begin
      cnt_q[hit_idx] <= cnt_m1;
    end
  end

endmodule

`default_nettype wire

//--- hw/r_last_ctrl.sv
/*
 * R channel controller
 * Forwards downstream R beats upstream and rebuilds last
 * from the beat counter that belongs to the beat's ID
 */

`default_nettype none

module r_last_ctrl (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            m_r_valid_i,
  output logic            m_r_ready_o,
  input  brst_pkg::id_t   m_r_id_i,
  input  brst_pkg::data_t m_r_data_i,
  output logic            s_r_valid_o,
  input  logic            s_r_ready_i,
  output brst_pkg::id_t   s_r_id_o,
  output brst_pkg::data_t s_r_data_o,
  output logic            s_r_last_o,
  output logic            lk_req_o,
  output brst_pkg::id_t   lk_id_o,
  input  logic            lk_hit_i,
  input  brst_pkg::len_t  lk_remain_i,
  output logic            lk_dec_o
);

  brst_pkg::r_state_e state_d, state_q;
  logic               last_d, last_q;

  // Payload goes straight through, only last is rebuilt
  assign s_r_id_o   = m_r_id_i;
  assign s_r_data_o = m_r_data_i;
  assign lk_id_o    = m_r_id_i;

  always_comb begin
    state_d     = state_q;
    last_d      = last_q;
    m_r_ready_o = 1'b0;
    s_r_valid_o = 1'b0;
    s_r_last_o  = 1'b0;
    lk_req_o    = 1'b0;
    lk_dec_o    = 1'b0;

    case (state_q)
      brst_pkg::R_FEED: begin
        if (m_r_valid_i) begin
          lk_req_o = 1'b1;
          if (lk_hit_i) begin
            last_d      = (lk_remain_i == '0);
            s_r_last_o  = last_d;
            lk_dec_o    = 1'b1;
            s_r_valid_o = 1'b1;
            if (s_r_ready_i) begin
              m_r_ready_o = 1'b1;
            end else begin
              // Counter already moved on, keep last for the replay
              state_d = brst_pkg::R_WAIT;
            end
          end
        end
      end
      brst_pkg::R_WAIT: begin
        s_r_valid_o = m_r_valid_i;
        s_r_last_o  = last_q;
        if (m_r_valid_i && s_r_ready_i) begin
          m_r_ready_o = 1'b1;
          state_d     = brst_pkg::R_FEED;
        end
      end
      default: state_d = brst_pkg::R_FEED;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= brst_pkg::R_FEED;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/burst_split_rd_top.sv
/*
 * Read-only AXI4 burst splitter, top level
 * Connects the AR splitter, the beat counter pool and the R controller
 */

`default_nettype none

module burst_split_rd_top #(
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Upstream AR
  input  logic              s_ar_valid_i,
  output logic              s_ar_ready_o,
  input  brst_pkg::id_t     s_ar_id_i,
  input  brst_pkg::addr_t   s_ar_addr_i,
  input  brst_pkg::len_t    s_ar_len_i,
  input  brst_pkg::size_t   s_ar_size_i,
  input  brst_pkg::burst_e  s_ar_burst_i,
  // Downstream AR, always single beat
  output logic              m_ar_valid_o,
  input  logic              m_ar_ready_i,
  output brst_pkg::id_t     m_ar_id_o,
  output brst_pkg::addr_t   m_ar_addr_o,
  // Downstream R
  input  logic              m_r_valid_i,
  output logic              m_r_ready_o,
  input  brst_pkg::id_t     m_r_id_i,
  input  brst_pkg::data_t   m_r_data_i,
  // Upstream R
  output logic              s_r_valid_o,
  input  logic              s_r_ready_i,
  output brst_pkg::id_t     s_r_id_o,
  output brst_pkg::data_t   s_r_data_o,
  output logic              s_r_last_o
);

  logic            alloc_req;
  logic            alloc_gnt;
  brst_pkg::id_t   alloc_id;
  brst_pkg::len_t  alloc_len;
  logic            lk_req;
  brst_pkg::id_t   lk_id;
  logic            lk_hit;
  brst_pkg::len_t  lk_remain;
  logic            lk_dec;

  ar_splitter u_ar_splitter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_size_i  (s_ar_size_i),
    .s_ar_burst_i (s_ar_burst_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .alloc_req_o  (alloc_req),
    .alloc_gnt_i  (alloc_gnt),
    .alloc_id_o   (alloc_id),
    .alloc_len_o  (alloc_len)
  );

  rd_len_counters #(
    .MAX_TXNS (MAX_TXNS)
  ) u_rd_len_counters (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .alloc_req_i (alloc_req),
    .alloc_gnt_o (alloc_gnt),
    .alloc_id_i  (alloc_id),
    .alloc_len_i (alloc_len),
    .lk_req_i    (lk_req),
    .lk_id_i     (lk_id),
    .lk_hit_o    (lk_hit),
    .lk_remain_o (lk_remain),
    .lk_dec_i    (lk_dec)
  );

  r_last_ctrl u_r_last_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .s_r_valid_o (s_r_valid_o),
    .s_r_ready_i (s_r_ready_i),
    .s_r_id_o    (s_r_id_o),
    .s_r_data_o  (s_r_data_o),
    .s_r_last_o  (s_r_last_o),
    .lk_req_o    (lk_req),
    .lk_id_o     (lk_id),
    .lk_hit_i    (lk_hit),
    .lk_remain_i (lk_remain),
    .lk_dec_o    (lk_dec)
  );

endmodule

`default_nettype wire

//--- dv/rd_slave_model.sv
/*
 * Downstream single-beat read slave
 * Random AR ready, R beats in order after a random gap
 * Read data is the read address XOR a fixed pattern
 */

`default_nettype none

module rd_slave_model #(
  parameter brst_pkg::data_t DATA_XOR = '0
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            ar_valid_i,
  output logic            ar_ready_o,
  input  brst_pkg::id_t   ar_id_i,
  input  brst_pkg::addr_t ar_addr_i,
  output logic            r_valid_o,
  input  logic            r_ready_i,
  output brst_pkg::id_t   r_id_o,
  output brst_pkg::data_t r_data_o
);

  brst_pkg::id_t   pend_id   [$];
  brst_pkg::addr_t pend_addr [$];

  initial begin
    logic        r_taken;
    int unsigned gap;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_id_o     = '0;
    r_data_o   = '0;
    r_taken    = 1'b0;
    gap        = 0;
    forever begin
      // Handshakes are taken at the rising edge
      @(posedge clk_i);
      if (!rst_n_i) begin
        pend_id.delete();
        pend_addr.delete();
        r_taken = 1'b0;
      end else begin
        if (ar_valid_i && ar_ready_o) begin
          pend_id.push_back(ar_id_i);
          pend_addr.push_back(ar_addr_i);
        end
        if (r_valid_o && r_ready_i) begin
          r_taken = 1'b1;
        end
      end

      // Outputs move on the falling edge
      @(negedge clk_i);
      if (!rst_n_i) begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        gap        = 0;
      end else begin
        ar_ready_o = ($urandom_range(0, 3) != 0);
        if (r_taken) begin
          r_valid_o = 1'b0;
          r_taken   = 1'b0;
          gap       = $urandom_range(0, 3);
        end
        if (!r_valid_o) begin
          if (gap > 0) begin
            gap--;
          end else if (pend_id.size() > 0) begin
            r_id_o    = pend_id.pop_front();
            r_data_o  = pend_addr.pop_front() ^ DATA_XOR;
            r_valid_o = 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/burst_split_rd_checker.sv
/*
 * Concurrent assertions on the burst splitter ports
 * Bound into the top level of the design
 */

`default_nettype none

module burst_split_rd_checker (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            m_ar_valid_o,
  input logic            m_ar_ready_i,
  input brst_pkg::id_t   m_ar_id_o,
  input brst_pkg::addr_t m_ar_addr_o,
  input logic            m_r_ready_o,
  input logic            s_r_valid_o,
  input logic            s_r_ready_i
);

  // Downstream stays quiet while reset is applied
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> (!m_ar_valid_o && !m_r_ready_o))
    else $error("Downstream AR valid or R ready high during reset");

  // A stalled downstream read keeps its payload
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_ar_valid_o && !m_ar_ready_i) |=>
      (m_ar_valid_o && $stable(m_ar_id_o) && $stable(m_ar_addr_o)))
    else $error("Downstream AR dropped or changed before ready");

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_r_valid_o && !s_r_ready_i) |=> s_r_valid_o)
    else $error("Upstream R valid dropped before ready");

endmodule

bind burst_split_rd_top burst_split_rd_checker u_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .m_ar_valid_o (m_ar_valid_o),
  .m_ar_ready_i (m_ar_ready_i),
  .m_ar_id_o    (m_ar_id_o),
  .m_ar_addr_o  (m_ar_addr_o),
  .m_r_ready_o  (m_r_ready_o),
  .s_r_valid_o  (s_r_valid_o),
  .s_r_ready_i  (s_r_ready_i)
);

`default_nettype wire

//--- dv/tb_burst_split_rd.sv
/*
 * Testbench for the read-only AXI4 burst splitter
 * Clock and reset, stimulus table, upstream AR driver,
 * monitors with compare tasks, and the run timeout
 */

`default_nettype none

module tb_burst_split_rd;

  localparam brst_pkg::data_t DATA_XOR   = 32'hc3a5_5a3c;
  localparam int unsigned     NUM_BURSTS = 10;

  // One row per burst, beats is the expected number of single reads
  typedef struct packed {
    brst_pkg::id_t    id;
    brst_pkg::addr_t  addr;
    brst_pkg::len_t   len;
    brst_pkg::size_t  size;
    brst_pkg::burst_e burst;
    int unsigned      beats;
  } burst_row_t;

  typedef struct packed {
    brst_pkg::id_t   id;
    brst_pkg::addr_t addr;
  } ar_exp_t;

  typedef struct packed {
    brst_pkg::id_t   id;
    brst_pkg::data_t data;
    logic            last;
  } r_exp_t;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic             s_ar_valid_i;
  logic             s_ar_ready_o;
  brst_pkg::id_t    s_ar_id_i;
  brst_pkg::addr_t  s_ar_addr_i;
  brst_pkg::len_t   s_ar_len_i;
  brst_pkg::size_t  s_ar_size_i;
  brst_pkg::burst_e s_ar_burst_i;
  logic             m_ar_valid_o;
  logic             m_ar_ready_i;
  brst_pkg::id_t    m_ar_id_o;
  brst_pkg::addr_t  m_ar_addr_o;
  logic             m_r_valid_i;
  logic             m_r_ready_o;
  brst_pkg::id_t    m_r_id_i;
  brst_pkg::data_t  m_r_data_i;
  logic             s_r_valid_o;
  logic             s_r_ready_i;
  brst_pkg::id_t    s_r_id_o;
  brst_pkg::data_t  s_r_data_o;
  logic             s_r_last_o;

  burst_row_t  stim [NUM_BURSTS];
  ar_exp_t     exp_ar [$];
  r_exp_t      exp_r [$];
  int unsigned total_beats = 0;
  int unsigned beats_seen  = 0;
  int unsigned cycle_limit = 0;
  int unsigned cycles      = 0;

  always #50 clk_i = ~clk_i;

  burst_split_rd_top #(
    .MAX_TXNS (4)
  ) dut0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_size_i  (s_ar_size_i),
    .s_ar_burst_i (s_ar_burst_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .m_r_id_i     (m_r_id_i),
    .m_r_data_i   (m_r_data_i),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .s_r_id_o     (s_r_id_o),
    .s_r_data_o   (s_r_data_o),
    .s_r_last_o   (s_r_last_o)
  );

  rd_slave_model #(
    .DATA_XOR (DATA_XOR)
  ) u_slave (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_valid_i (m_ar_valid_o),
    .ar_ready_o (m_ar_ready_i),
    .ar_id_i    (m_ar_id_o),
    .ar_addr_i  (m_ar_addr_o),
    .r_valid_o  (m_r_valid_i),
    .r_ready_i  (m_r_ready_o),
    .r_id_o     (m_r_id_i),
    .r_data_o   (m_r_data_i)
  );

  // --------------------------------------------------------------------------
  // Stimulus table
  // --------------------------------------------------------------------------
  task automatic load_table();
    stim[0] = '{4'h1, 32'h0000_1000, 8'd0,  3'd2, brst_pkg::BURST_INCR,  1};
    stim[1] = '{4'h2, 32'h0000_2000, 8'd7,  3'd2, brst_pkg::BURST_INCR,  8};
    stim[2] = '{4'h3, 32'h0000_3001, 8'd3,  3'd0, brst_pkg::BURST_INCR,  4};
    stim[3] = '{4'h4, 32'h0000_4040, 8'd5,  3'd2, brst_pkg::BURST_FIXED, 6};
    stim[4] = '{4'h5, 32'h0000_5000, 8'd15, 3'd3, brst_pkg::BURST_INCR,  16};
    // Same ID as the row before, has to wait for its counter
    stim[5] = '{4'h5, 32'h0000_6002, 8'd2,  3'd1, brst_pkg::BURST_INCR,  3};
    stim[6] = '{4'h6, 32'h0000_7000, 8'd0,  3'd2, brst_pkg::BURST_FIXED, 1};
    stim[7] = '{4'h7, 32'h0000_8000, 8'd4,  3'd2, brst_pkg::BURST_INCR,  5};
    stim[8] = '{4'h8, 32'h0000_9010, 8'd3,  3'd2, brst_pkg::BURST_FIXED, 4};
    stim[9] = '{4'h9, 32'h0000_a000, 8'd9,  3'd2, brst_pkg::BURST_INCR,  10};
  endtask

  // Address of beat k, FIXED repeats, INCR steps by 2^size
  function automatic brst_pkg::addr_t beat_addr(input burst_row_t row, input int unsigned k);
    if (row.burst == brst_pkg::BURST_FIXED) begin
      return row.addr;
    end
    return row.addr + brst_pkg::addr_t'(k << row.size);
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_addr(input brst_pkg::addr_t got, input brst_pkg::addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: read address 0x%08h, expected 0x%08h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input brst_pkg::id_t got, input brst_pkg::id_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: read ID %0d, expected %0d", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input brst_pkg::data_t got, input brst_pkg::data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: R data 0x%08h, expected 0x%08h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: R last %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitors, one process so AR acceptance is seen before its first read
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    burst_row_t  row;
    ar_exp_t     ar_e;
    r_exp_t      r_e;
    int          idx;
    int unsigned row_idx;
    if (rst_n_i && s_ar_valid_i && s_ar_ready_o) begin
      row = stim[row_idx];
      row_idx++;
      for (int unsigned k = 0; k < row.beats; k++) begin
        ar_e.id   = row.id;
        ar_e.addr = beat_addr(row, k);
        exp_ar.push_back(ar_e);
        r_e.id    = row.id;
        r_e.data  = beat_addr(row, k) ^ DATA_XOR;
        r_e.last  = (k == row.beats - 1);
        exp_r.push_back(r_e);
      end
    end
    if (rst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      if (exp_ar.size() == 0) begin
        $display("Downstream read at 0x%08h while no read was expected", m_ar_addr_o);
        abort_run();
      end else begin
        ar_e = exp_ar.pop_front();
        check_id(m_ar_id_o, ar_e.id);
        check_addr(m_ar_addr_o, ar_e.addr);
      end
    end
    if (rst_n_i && s_r_valid_o && s_r_ready_i) begin
      idx = -1;
      // Oldest entry of this ID, bursts on one ID never overlap
      foreach (exp_r[i]) begin
        if ((idx < 0) && (exp_r[i].id == s_r_id_o)) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        $display("Upstream R beat with ID %0d that no burst is waiting for", s_r_id_o);
        abort_run();
      end else begin
        check_data(s_r_data_o, exp_r[idx].data);
        check_last(s_r_last_o, exp_r[idx].last);
        exp_r.delete(idx);
        beats_seen++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // Random upstream R back-pressure
  initial begin
    s_r_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      s_r_ready_i = rst_n_i && ($urandom_range(0, 3) != 0);
    end
  end

  task automatic send_burst(input burst_row_t row);
    @(negedge clk_i);
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = row.id;
    s_ar_addr_i  = row.addr;
    s_ar_len_i   = row.len;
    s_ar_size_i  = row.size;
    s_ar_burst_i = row.burst;
    do begin
      @(posedge clk_i);
    end while (!s_ar_ready_o);
  endtask

  initial begin
    int leftover;
    void'($urandom(84479));
    rst_n_i      = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = brst_pkg::BURST_FIXED;
    load_table();
    foreach (stim[i]) begin
      total_beats += stim[i].beats;
    end
    cycle_limit = total_beats * 40 + 200;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    foreach (stim[i]) begin
      send_burst(stim[i]);
    end
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;

    wait (beats_seen == total_beats);
    // Quiet period to catch duplicated beats
    repeat (10) @(posedge clk_i);
    leftover = exp_ar.size() + exp_r.size();
    if (leftover == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("%0d expected transfers never arrived", leftover);
      $display("Verification failed");
      $fatal(1, "Run ended with missing transfers");
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/brst_pkg.sv
hw/ar_splitter.sv
hw/rd_len_counters.sv
hw/r_last_ctrl.sv
hw/burst_split_rd_top.sv
dv/rd_slave_model.sv
dv/burst_split_rd_checker.sv
dv/tb_burst_split_rd.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the read burst splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_burst_split_rd
LOG=sim.log

verilator --binary --timing --assert \
  --top-module "$TOP" -f filelist.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

grep -q "^Verification passed$" "$LOG"
if [ $? -ne 0 ]; then
  echo "Pass message not found in $LOG"
  exit 1
fi

exit 0
